// ==== ahb_axi_pkg.sv ====
// Bus widths, AHB encodings, bridge states and AXI response type shared by the bridge and its testbench
package ahb_axi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 64;
  localparam int unsigned strb_w = data_w / 8;

  typedef logic [addr_w-1:0] addr_t;
  typedef logic [data_w-1:0] data_t;
  typedef logic [strb_w-1:0] strb_t;

  //////////////////////////////////////////////////////////////////////
  // AHB encodings
  //////////////////////////////////////////////////////////////////////

  // Bit 1 set marks an active transfer
  typedef enum logic [1:0] {
    htrans_idle   = 2'b00,
    htrans_busy   = 2'b01,
    htrans_nonseq = 2'b10,
    htrans_seq    = 2'b11
  } htrans_t;

  // Transfer size as log2 of the byte count
  typedef enum logic [2:0] {
    hsize_byte  = 3'b000,
    hsize_half  = 3'b001,
    hsize_word  = 3'b010,
    hsize_dword = 3'b011
  } hsize_t;

  // Bridge FSM states
  typedef enum logic [1:0] {
    st_idle  = 2'b00,
    st_write = 2'b01,
    st_read  = 2'b10,
    st_pend  = 2'b11
  } bridge_state_t;

  // AXI response, nonzero is an error
  typedef logic [1:0] axi_resp_t;

endpackage

// ==== mem_map_pkg.sv ====
// Memory map of the two closely coupled regions, used by the bridge address decoder and the testbench
package mem_map_pkg;

  //////////////////////////////////////////////////////////////////////
  // Region bases
  //////////////////////////////////////////////////////////////////////

  // Data CCM
  localparam logic [31:0] dccm_base = 32'hF004_0000;

  // Instruction CCM
  localparam logic [31:0] iccm_base = 32'hEE00_0000;

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  // Address bits from here upward select the region
  localparam int unsigned region_lsb = 16;

  // Clear to drop the ICCM decode so ICCM accesses error out
  localparam logic iccm_enable = 1'b1;

endpackage

// ==== ahb_slave_front.sv ====
// AHB-Lite slave side of the bridge; samples transfers, checks them and loads the command buffer
module ahb_slave_front
  import ahb_axi_pkg::*;
  import mem_map_pkg::*;
(
  input  logic     bus_clk,
  input  logic     rst_l,

  // AHB slave port
  input  logic     hsel,
  input  addr_t    haddr,
  input  data_t    hwdata,
  input  logic     hwrite,
  input  hsize_t   hsize,
  input  htrans_t  htrans,
  input  logic     hready_in,
  output logic     hreadyout,
  output logic     hresp,

  // Command buffer
  input  logic       cmd_full,
  input  logic       cmd_pending_write,
  output logic       cmd_load,
  output logic       cmd_flush,
  output logic       cmd_write,
  output logic [1:0] cmd_size,
  output addr_t      cmd_addr,
  output strb_t      cmd_strb,
  output data_t      cmd_wdata,

  // Read return from the AXI side
  input  logic     rd_done,
  input  logic     rd_error
);

  bridge_state_t state;
  bridge_state_t nxt_state;
  logic          state_en;

  // Registered address phase
  logic     hready;
  htrans_t  htrans_in;
  htrans_t  htrans_q;
  hsize_t   hsize_q;
  logic     hwrite_q;
  addr_t    haddr_q;
  logic     addr_en;

  // Error tracking
  logic     hresp_q;
  logic     hready_q;
  logic     read_error_in;
  logic     read_error;

  // Decode
  logic     in_dccm;
  logic     in_iccm;
  logic     illegal;
  strb_t    wstrb;

  assign hready    = hreadyout & hready_in;
  // Unselected cycles look idle
  assign htrans_in = hsel ? htrans : htrans_idle;
  // Capture only on an accepted active transfer
  assign addr_en   = hready & htrans[1];

  //////////////////////////////////////////////////////////////////////
  // Bridge FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    nxt_state     = st_idle;
    state_en      = 1'b0;
    cmd_load      = 1'b0;
    read_error_in = 1'b0;
    case (state)
      st_idle: begin
        // Wait for a new transfer
        nxt_state = hwrite ? st_write : st_read;
        state_en  = hready & htrans[1] & hsel;
      end
      st_write: begin
        // Write data is on the bus this cycle
        if (hresp || htrans == htrans_idle || !hsel) begin
          nxt_state = st_idle;
        end else begin
          nxt_state = hwrite ? st_write : st_read;
        end
        state_en = ~cmd_full | hresp;
        // No load on error or while the master is busy
        cmd_load = ~cmd_full & ~(hresp | (htrans == htrans_busy && hsel));
      end
      st_read: begin
        // Error ends the transfer, else wait for data
        nxt_state = hresp ? st_idle : st_pend;
        state_en  = ~cmd_full | hresp;
        cmd_load  = ~hresp & ~cmd_full;
      end
      st_pend: begin
        // Read issued and waiting on R
        nxt_state     = st_idle;
        state_en      = rd_done;
        read_error_in = rd_done & rd_error;
      end
      default: begin
        nxt_state = st_idle;
        state_en  = 1'b1;
      end
    endcase
  end

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      state <= st_idle;
    end else if (state_en) begin
      state <= nxt_state;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Address phase and error registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      htrans_q   <= htrans_idle;
      hresp_q    <= 1'b0;
      hready_q   <= 1'b0;
      read_error <= 1'b0;
    end else begin
      htrans_q   <= htrans_in;
      hresp_q    <= hresp;
      hready_q   <= hready;
      // High for one cycle only
      read_error <= read_error_in;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      hsize_q  <= hsize_byte;
      hwrite_q <= 1'b0;
    end else if (addr_en) begin
      hsize_q  <= hsize;
      hwrite_q <= hwrite;
    end
  end

  // Address is payload, qualified by htrans_q
  always_ff @(posedge bus_clk) begin
    if (addr_en) begin
      haddr_q <= haddr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Legality check
  //////////////////////////////////////////////////////////////////////

  assign in_dccm = haddr_q[addr_w-1:region_lsb] == dccm_base[addr_w-1:region_lsb];
  assign in_iccm = iccm_enable & (haddr_q[addr_w-1:region_lsb] == iccm_base[addr_w-1:region_lsb]);

  always_comb begin
    // Outside both regions
    illegal = ~(in_dccm | in_iccm);
    // ICCM any access or DCCM write must be word or wider
    if ((in_iccm || (in_dccm && hwrite_q)) && !(hsize_q == hsize_word || hsize_q == hsize_dword)) begin
      illegal = 1'b1;
    end
    // Natural alignment
    if (hsize_q == hsize_half && haddr_q[0]) begin
      illegal = 1'b1;
    end
    if (hsize_q == hsize_word && |haddr_q[1:0]) begin
      illegal = 1'b1;
    end
    if (hsize_q == hsize_dword && |haddr_q[2:0]) begin
      illegal = 1'b1;
    end
  end

  // First cycle from the decode or read error, second from hresp_q
  assign hresp = ((htrans_q != htrans_idle) & (state != st_idle) & illegal) |
                 read_error |
                 (hresp_q & ~hready_q);

  // Low then high across the two error cycles
  assign hreadyout = hresp ? (hresp_q & ~hready_q) :
                     ((~cmd_full | (state == st_idle)) &
                      ~(state == st_read || state == st_pend) & ~read_error);

  //////////////////////////////////////////////////////////////////////
  // Command fields
  //////////////////////////////////////////////////////////////////////

  // Byte lanes from size and low address
  always_comb begin
    case (hsize_q)
      hsize_byte:  wstrb = strb_t'(8'b0000_0001) << haddr_q[2:0];
      hsize_half:  wstrb = strb_t'(8'b0000_0011) << haddr_q[2:0];
      hsize_word:  wstrb = strb_t'(8'b0000_1111) << haddr_q[2:0];
      hsize_dword: wstrb = '1;
      default:     wstrb = '0;
    endcase
  end

  // Drop a buffered read when the transfer errors
  assign cmd_flush = hresp & ~cmd_pending_write;

  assign cmd_write = hwrite_q;
  assign cmd_size  = hsize_q[1:0];
  assign cmd_addr  = haddr_q;
  assign cmd_strb  = wstrb;
  // Write data arrives in the data phase
  assign cmd_wdata = hwdata;

endmodule

// ==== cmd_buffer.sv ====
// One-entry command holding register between the AHB front and the AXI master port
module cmd_buffer
  import ahb_axi_pkg::*;
(
  input  logic       bus_clk,
  input  logic       rst_l,

  // From the front
  input  logic       cmd_load,
  input  logic       cmd_flush,
  input  logic       cmd_write,
  input  logic [1:0] cmd_size,
  input  addr_t      cmd_addr,
  input  strb_t      cmd_strb,
  input  data_t      cmd_wdata,

  // From the AXI port
  input  logic       cmd_taken,

  // Status back to the front
  output logic       cmd_full,
  output logic       cmd_pending_write,

  // Stored command
  output logic       cmd_valid,
  output logic       buf_write,
  output logic [1:0] buf_size,
  output addr_t      buf_addr,
  output strb_t      buf_strb,
  output data_t      buf_wdata
);

  logic clear;

  // Take without a fresh load, or a flush
  assign clear = (cmd_taken & ~cmd_load) | cmd_flush;

  // Still occupied after this cycle
  assign cmd_full          = cmd_valid & ~cmd_taken;
  assign cmd_pending_write = cmd_valid & buf_write;

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      cmd_valid <= 1'b0;
      buf_write <= 1'b0;
    end else begin
      cmd_valid <= ~clear & (cmd_load | cmd_valid);
      if (cmd_load) begin
        buf_write <= cmd_write;
      end
    end
  end

  // Command payload
  always_ff @(posedge bus_clk) begin
    if (cmd_load) begin
      buf_size  <= cmd_size;
      buf_addr  <= cmd_addr;
      buf_strb  <= cmd_strb;
      buf_wdata <= cmd_wdata;
    end
  end

endmodule

// ==== axi_master_port.sv ====
// AXI master side of the bridge; issues the buffered command and returns read data to AHB
module axi_master_port
  import ahb_axi_pkg::*;
(
  input  logic       bus_clk,
  input  logic       rst_l,

  // Buffered command
  input  logic       cmd_valid,
  input  logic       buf_write,
  input  logic [1:0] buf_size,
  input  addr_t      buf_addr,
  input  strb_t      buf_strb,
  input  data_t      buf_wdata,
  output logic       cmd_taken,

  // AXI write address and data
  output logic       aw_valid,
  output addr_t      aw_addr,
  output logic [2:0] aw_size,
  input  logic       aw_ready,
  output logic       w_valid,
  output data_t      w_data,
  output strb_t      w_strb,
  output logic       b_ready,

  // AXI read address and data
  output logic       ar_valid,
  output addr_t      ar_addr,
  output logic [2:0] ar_size,
  input  logic       ar_ready,
  input  logic       r_valid,
  input  data_t      r_data,
  input  axi_resp_t  r_resp,
  output logic       r_ready,

  // Read return to the front
  output logic       rd_done,
  output logic       rd_error,
  output data_t      hrdata
);

  // AW and W go out together from one entry
  assign aw_valid = cmd_valid & buf_write;
  assign aw_addr  = buf_addr;
  assign aw_size  = {1'b0, buf_size};
  assign w_valid  = cmd_valid & buf_write;
  assign w_data   = buf_wdata;
  assign w_strb   = buf_strb;

  assign ar_valid = cmd_valid & ~buf_write;
  assign ar_addr  = buf_addr;
  assign ar_size  = {1'b0, buf_size};

  // AHB reads block, so R always has room
  assign r_ready  = 1'b1;
  // No write response goes back to AHB
  assign b_ready  = 1'b1;

  assign cmd_taken = (aw_valid & aw_ready) | (ar_valid & ar_ready);

  // R beat counts only with no write in the buffer
  assign rd_done  = r_valid & ~buf_write;
  assign rd_error = rd_done & (r_resp != 2'b00);

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      hrdata <= '0;
    end else if (rd_done) begin
      hrdata <= r_data;
    end
  end

endmodule

// ==== ahb_to_axi_bridge.sv ====
// Top level of the AHB-Lite to AXI bridge; instantiate this to join an AHB master to an AXI slave
module ahb_to_axi_bridge
  import ahb_axi_pkg::*;
(
  input  logic       bus_clk,
  input  logic       rst_l,

  // AHB-Lite slave
  input  logic       hsel,
  input  addr_t      haddr,
  input  data_t      hwdata,
  input  logic       hwrite,
  input  hsize_t     hsize,
  input  htrans_t    htrans,
  input  logic       hready_in,
  output data_t      hrdata,
  output logic       hreadyout,
  output logic       hresp,

  // AXI master write side
  output logic       aw_valid,
  output addr_t      aw_addr,
  output logic [2:0] aw_size,
  input  logic       aw_ready,
  output logic       w_valid,
  output data_t      w_data,
  output strb_t      w_strb,
  output logic       b_ready,

  // AXI master read side
  output logic       ar_valid,
  output addr_t      ar_addr,
  output logic [2:0] ar_size,
  input  logic       ar_ready,
  input  logic       r_valid,
  input  data_t      r_data,
  input  axi_resp_t  r_resp,
  output logic       r_ready
);

  // Front to buffer
  logic       cmd_load;
  logic       cmd_flush;
  logic       cmd_write;
  logic [1:0] cmd_size;
  addr_t      cmd_addr;
  strb_t      cmd_strb;
  data_t      cmd_wdata;
  logic       cmd_full;
  logic       cmd_pending_write;

  // Buffer to AXI port
  logic       cmd_valid;
  logic       cmd_taken;
  logic       buf_write;
  logic [1:0] buf_size;
  addr_t      buf_addr;
  strb_t      buf_strb;
  data_t      buf_wdata;

  // Read return
  logic       rd_done;
  logic       rd_error;

  ahb_slave_front u_front (
    .bus_clk           (bus_clk),
    .rst_l             (rst_l),
    .hsel              (hsel),
    .haddr             (haddr),
    .hwdata            (hwdata),
    .hwrite            (hwrite),
    .hsize             (hsize),
    .htrans            (htrans),
    .hready_in         (hready_in),
    .hreadyout         (hreadyout),
    .hresp             (hresp),
    .cmd_full          (cmd_full),
    .cmd_pending_write (cmd_pending_write),
    .cmd_load          (cmd_load),
    .cmd_flush         (cmd_flush),
    .cmd_write         (cmd_write),
    .cmd_size          (cmd_size),
    .cmd_addr          (cmd_addr),
    .cmd_strb          (cmd_strb),
    .cmd_wdata         (cmd_wdata),
    .rd_done           (rd_done),
    .rd_error          (rd_error)
  );

  cmd_buffer u_buffer (
    .bus_clk           (bus_clk),
    .rst_l             (rst_l),
    .cmd_load          (cmd_load),
    .cmd_flush         (cmd_flush),
    .cmd_write         (cmd_write),
    .cmd_size          (cmd_size),
    .cmd_addr          (cmd_addr),
    .cmd_strb          (cmd_strb),
    .cmd_wdata         (cmd_wdata),
    .cmd_taken         (cmd_taken),
    .cmd_full          (cmd_full),
    .cmd_pending_write (cmd_pending_write),
    .cmd_valid         (cmd_valid),
    .buf_write         (buf_write),
    .buf_size          (buf_size),
    .buf_addr          (buf_addr),
    .buf_strb          (buf_strb),
    .buf_wdata         (buf_wdata)
  );

  axi_master_port u_axi (
    .bus_clk   (bus_clk),
    .rst_l     (rst_l),
    .cmd_valid (cmd_valid),
    .buf_write (buf_write),
    .buf_size  (buf_size),
    .buf_addr  (buf_addr),
    .buf_strb  (buf_strb),
    .buf_wdata (buf_wdata),
    .cmd_taken (cmd_taken),
    .aw_valid  (aw_valid),
    .aw_addr   (aw_addr),
    .aw_size   (aw_size),
    .aw_ready  (aw_ready),
    .w_valid   (w_valid),
    .w_data    (w_data),
    .w_strb    (w_strb),
    .b_ready   (b_ready),
    .ar_valid  (ar_valid),
    .ar_addr   (ar_addr),
    .ar_size   (ar_size),
    .ar_ready  (ar_ready),
    .r_valid   (r_valid),
    .r_data    (r_data),
    .r_resp    (r_resp),
    .r_ready   (r_ready),
    .rd_done   (rd_done),
    .rd_error  (rd_error),
    .hrdata    (hrdata)
  );

endmodule

// ==== axi_slave_model.sv ====
// Testbench AXI slave with sparse memory, random delays and an error range; logs each command
module axi_slave_model
  import ahb_axi_pkg::*;
#(
  parameter addr_t err_lo = '0,
  parameter addr_t err_hi = '0
) (
  input  logic       bus_clk,
  input  logic       rst_l,

  // Write address and data
  input  logic       aw_valid,
  input  addr_t      aw_addr,
  input  logic [2:0] aw_size,
  output logic       aw_ready,
  input  logic       w_valid,
  input  data_t      w_data,
  input  strb_t      w_strb,

  // Read address and data
  input  logic       ar_valid,
  input  addr_t      ar_addr,
  input  logic [2:0] ar_size,
  output logic       ar_ready,
  output logic       r_valid,
  output data_t      r_data,
  output axi_resp_t  r_resp,
  input  logic       r_ready,

  // One log pulse per accepted AW or AR
  output logic       log_valid,
  output logic       log_write,
  output addr_t      log_addr,
  output logic [2:0] log_size,
  output data_t      log_data,
  output strb_t      log_strb
);

  timeunit 1ns;
  timeprecision 1ps;

  data_t      mem [addr_t];
  logic       aw_hs;
  logic       ar_hs;
  logic       r_hs;
  addr_t      hs_addr;
  logic [2:0] hs_size;
  data_t      hs_data;
  strb_t      hs_strb;
  addr_t      rd_addr;
  logic       rd_busy;
  int         rd_wait;

  // Unwritten lines read back a pattern made from the line address
  function automatic data_t read_line(input addr_t line);
    if (mem.exists(line)) begin
      return mem[line];
    end
    return {line, line ^ 32'hA5A5_5A5A};
  endfunction

  initial begin
    aw_ready  = 1'b0;
    ar_ready  = 1'b0;
    r_valid   = 1'b0;
    r_data    = '0;
    r_resp    = 2'b00;
    log_valid = 1'b0;
    log_write = 1'b0;
    log_addr  = '0;
    log_size  = '0;
    log_data  = '0;
    log_strb  = '0;
    rd_busy   = 1'b0;
    rd_wait   = 0;
    rd_addr   = '0;
  end

  always begin
    // Handshakes sampled mid-cycle complete at the next rising edge
    @(negedge bus_clk);
    aw_hs   = rst_l && aw_valid && w_valid && aw_ready;
    ar_hs   = rst_l && ar_valid && ar_ready;
    r_hs    = rst_l && r_valid && r_ready;
    hs_addr = aw_hs ? aw_addr : ar_addr;
    hs_size = aw_hs ? aw_size : ar_size;
    hs_data = w_data;
    hs_strb = w_strb;
    if (aw_hs) begin
      r_data = read_line({aw_addr[31:3], 3'b000});
      for (int i = 0; i < strb_w; i++) begin
        if (w_strb[i]) begin
          r_data[i*8 +: 8] = w_data[i*8 +: 8];
        end
      end
      mem[{aw_addr[31:3], 3'b000}] = r_data;
    end
    @(posedge bus_clk);
    #1;
    log_valid = aw_hs | ar_hs;
    log_write = aw_hs;
    log_addr  = hs_addr;
    log_size  = hs_size;
    log_data  = aw_hs ? hs_data : '0;
    log_strb  = aw_hs ? hs_strb : '0;
    if (r_hs) begin
      r_valid = 1'b0;
    end
    if (ar_hs) begin
      rd_busy = 1'b1;
      rd_addr = hs_addr;
      rd_wait = $urandom % 4;
    end
    // Read data after a random delay with an error response inside the error range
    if (rd_busy && !r_valid && !ar_hs) begin
      if (rd_wait == 0) begin
        r_valid = 1'b1;
        r_data  = read_line({rd_addr[31:3], 3'b000});
        r_resp  = (rd_addr >= err_lo && rd_addr <= err_hi) ? 2'b10 : 2'b00;
        rd_busy = 1'b0;
      end else begin
        rd_wait = rd_wait - 1;
      end
    end
    aw_ready = rst_l && ($urandom % 3 != 0);
    ar_ready = rst_l && ($urandom % 3 != 0);
  end

endmodule

// ==== tb_ahb_to_axi.sv ====
// Bridge testbench top; drives directed and random AHB transfers and checks the AHB and AXI sides
module tb_ahb_to_axi
  import ahb_axi_pkg::*;
  import mem_map_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int    n_directed  = 16;
  localparam int    n_random    = 80;
  localparam int    n_transfers = n_directed + n_random;
  localparam int    cycle_limit = 40 * n_transfers + 200;
  localparam addr_t err_lo      = dccm_base + 32'h0000_F000;
  localparam addr_t err_hi      = dccm_base + 32'h0000_FFFF;

  typedef struct packed {
    logic  legal;
    strb_t strb;
  } exp_t;

  logic       bus_clk;
  logic       rst_l;
  logic       hsel;
  addr_t      haddr;
  data_t      hwdata;
  logic       hwrite;
  hsize_t     hsize;
  htrans_t    htrans;
  logic       hready_in;
  data_t      hrdata;
  logic       hreadyout;
  logic       hresp;
  logic       aw_valid;
  addr_t      aw_addr;
  logic [2:0] aw_size;
  logic       aw_ready;
  logic       w_valid;
  data_t      w_data;
  strb_t      w_strb;
  logic       b_ready;
  logic       ar_valid;
  addr_t      ar_addr;
  logic [2:0] ar_size;
  logic       ar_ready;
  logic       r_valid;
  data_t      r_data;
  axi_resp_t  r_resp;
  logic       r_ready;
  logic       log_valid;
  logic       log_write;
  addr_t      log_addr;
  logic [2:0] log_size;
  data_t      log_data;
  strb_t      log_strb;

  // Expected AXI commands in issue order
  logic       exp_write_q [$];
  addr_t      exp_addr_q [$];
  logic [2:0] exp_size_q [$];
  data_t      exp_data_q [$];
  strb_t      exp_strb_q [$];
  data_t      ref_mem [addr_t];
  int         mismatches;
  int         other_errors;
  int         cycles;

  ahb_to_axi_bridge DUT (.*);

  axi_slave_model #(.err_lo(err_lo), .err_hi(err_hi)) u_slave (.*);

  always #4 bus_clk = ~bus_clk;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Legality and byte lanes of one AHB transfer
  function automatic exp_t expected_response(input addr_t a, input hsize_t s, input logic w);
    exp_t r;
    logic dccm;
    logic iccm;
    dccm = a[31:16] == dccm_base[31:16];
    iccm = iccm_enable && a[31:16] == iccm_base[31:16];
    r.legal = dccm | iccm;
    // Sub-word only for DCCM reads
    if ((iccm || (dccm && w)) && (s == hsize_byte || s == hsize_half)) r.legal = 1'b0;
    if (s == hsize_half && a[0]) r.legal = 1'b0;
    if (s == hsize_word && a[1:0] != 2'b00) r.legal = 1'b0;
    if (s == hsize_dword && a[2:0] != 3'b000) r.legal = 1'b0;
    case (s)
      hsize_byte: r.strb = 8'h01 << a[2:0];
      hsize_half: r.strb = 8'h03 << a[2:0];
      hsize_word: r.strb = 8'h0F << a[2:0];
      default:    r.strb = 8'hFF;
    endcase
    return r;
  endfunction

  function automatic data_t ref_line(input addr_t line);
    if (ref_mem.exists(line)) begin
      return ref_mem[line];
    end
    return {line, line ^ 32'hA5A5_5A5A};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // AHB driver with completion checks
  //////////////////////////////////////////////////////////////////////

  task automatic run_transfer(input addr_t a, input hsize_t s, input logic w, input data_t d);
    exp_t  e;
    addr_t la;
    logic  want_err;
    logic  err_low;
    logic  err_end;
    data_t want_data;
    data_t merged;
    e        = expected_response(a, s, w);
    la       = {a[31:3], 3'b000};
    want_err = !e.legal || (!w && a >= err_lo && a <= err_hi);
    // Address phase
    @(posedge bus_clk);
    #1;
    hsel   = 1'b1;
    htrans = htrans_nonseq;
    haddr  = a;
    hsize  = s;
    hwrite = w;
    @(negedge bus_clk);
    while (!hreadyout) @(negedge bus_clk);
    if (e.legal) begin
      exp_write_q.push_back(w);
      exp_addr_q.push_back(a);
      exp_size_q.push_back({1'b0, s[1:0]});
      exp_data_q.push_back(d);
      exp_strb_q.push_back(e.strb);
      if (w) begin
        merged = ref_line(la);
        for (int i = 0; i < strb_w; i++) begin
          if (e.strb[i]) merged[i*8 +: 8] = d[i*8 +: 8];
        end
        ref_mem[la] = merged;
      end
    end
    want_data = ref_line(la);
    // Data phase
    @(posedge bus_clk);
    #1;
    htrans  = htrans_idle;
    hwdata  = d;
    err_low = 1'b0;
    @(negedge bus_clk);
    while (!hreadyout) begin
      if (hresp) err_low = 1'b1;
      @(negedge bus_clk);
    end
    err_end = hresp;
    if (want_err) begin
      assert (err_low && err_end) else begin
        $display("MISMATCH at %0t: no two-cycle error for addr %h size %0d write %0b",
                 $time, a, s, w);
        mismatches++;
      end
    end else begin
      assert (!err_low && !err_end) else begin
        $display("MISMATCH at %0t: error response on legal addr %h size %0d write %0b",
                 $time, a, s, w);
        mismatches++;
      end
      if (!w) begin
        assert (hrdata == want_data) else begin
          $display("MISMATCH at %0t: read %h got %h expected %h", $time, a, hrdata, want_data);
          mismatches++;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI command compare
  //////////////////////////////////////////////////////////////////////

  always @(negedge bus_clk) begin
    // R and B ready stay high and AW valid travels with W valid
    assert (r_ready && b_ready && aw_valid == w_valid) else begin
      $display("MISMATCH at %0t: r_ready %0b b_ready %0b aw_valid %0b w_valid %0b",
               $time, r_ready, b_ready, aw_valid, w_valid);
      mismatches++;
    end
    if (log_valid) begin
      assert (exp_addr_q.size() != 0) else begin
        $display("AXI command to %h was issued with no legal transfer waiting for it", log_addr);
        other_errors++;
      end
      if (exp_addr_q.size() != 0) begin
        assert (log_write == exp_write_q[0] && log_addr == exp_addr_q[0] &&
                log_size == exp_size_q[0]) else begin
          $display("MISMATCH at %0t: command write %0b addr %h size %0d expected %0b %h %0d",
                   $time, log_write, log_addr, log_size, exp_write_q[0], exp_addr_q[0],
                   exp_size_q[0]);
          mismatches++;
        end
        // Only writes carry data and lanes
        if (log_write) begin
          assert (log_data == exp_data_q[0] && log_strb == exp_strb_q[0]) else begin
            $display("MISMATCH at %0t: write %h data %h strb %h expected %h %h", $time,
                     log_addr, log_data, log_strb, exp_data_q[0], exp_strb_q[0]);
            mismatches++;
          end
        end
        void'(exp_write_q.pop_front());
        void'(exp_addr_q.pop_front());
        void'(exp_size_q.pop_front());
        void'(exp_data_q.pop_front());
        void'(exp_strb_q.pop_front());
      end
    end
  end

  // Run limit
  always @(posedge bus_clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, a transfer or AXI command never completed", cycles);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    addr_t  a;
    hsize_t s;
    int     region;
    void'($urandom(21));
    bus_clk      = 1'b0;
    rst_l        = 1'b0;
    hsel         = 1'b0;
    haddr        = '0;
    hwdata       = '0;
    hwrite       = 1'b0;
    hsize        = hsize_byte;
    htrans       = htrans_idle;
    hready_in    = 1'b1;
    mismatches   = 0;
    other_errors = 0;
    cycles       = 0;
    repeat (3) @(posedge bus_clk);
    #1;
    rst_l = 1'b1;

    // Idle outputs after reset
    @(negedge bus_clk);
    assert (hreadyout && !hresp && !aw_valid && !w_valid && !ar_valid) else begin
      $display("MISMATCH at %0t: outputs not idle after reset", $time);
      mismatches++;
    end

    // Legal DCCM writes then reads back
    run_transfer(dccm_base + 32'h0, hsize_word, 1'b1, 64'h1111_2222_3333_4444);
    run_transfer(dccm_base + 32'h4, hsize_word, 1'b1, 64'h5555_6666_7777_8888);
    run_transfer(dccm_base + 32'h8, hsize_dword, 1'b1, 64'h0123_4567_89AB_CDEF);
    run_transfer(dccm_base + 32'h10, hsize_dword, 1'b1, 64'hFEDC_BA98_7654_3210);
    run_transfer(dccm_base + 32'h0, hsize_dword, 1'b0, '0);
    run_transfer(dccm_base + 32'h4, hsize_word, 1'b0, '0);
    run_transfer(dccm_base + 32'hA, hsize_half, 1'b0, '0);
    run_transfer(dccm_base + 32'h11, hsize_byte, 1'b0, '0);
    run_transfer(iccm_base + 32'h0, hsize_dword, 1'b1, 64'hCAFE_F00D_DEAD_BEEF);
    run_transfer(iccm_base + 32'h4, hsize_word, 1'b0, '0);

    // Rejected transfers
    run_transfer(32'h1000_0000, hsize_word, 1'b0, '0);
    run_transfer(dccm_base + 32'h2, hsize_word, 1'b0, '0);
    run_transfer(iccm_base + 32'h1, hsize_byte, 1'b0, '0);
    run_transfer(dccm_base + 32'h8, hsize_half, 1'b1, 64'hFFFF);
    run_transfer(dccm_base + 32'h4, hsize_dword, 1'b1, '1);

    // Slave error on read
    run_transfer(err_lo, hsize_word, 1'b0, '0);

    // Random mix under random AXI delays
    for (int n = 0; n < n_random; n++) begin
      region = $urandom % 8;
      a      = 32'((($urandom % 4) * 8) + ($urandom % 8));
      if (region < 4) a = dccm_base + a;
      else if (region < 6) a = iccm_base + a;
      else if (region == 6) a = 32'h2000_0000 + a;
      else a = err_lo + a;
      s = hsize_t'($urandom % 4);
      run_transfer(a, s, 1'($urandom % 2), {$urandom, $urandom});
    end

    // Let the last commands drain
    while (exp_addr_q.size() != 0) @(negedge bus_clk);
    repeat (5) @(negedge bus_clk);

    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
ahb_axi_pkg.sv
mem_map_pkg.sv
ahb_slave_front.sv
cmd_buffer.sv
axi_master_port.sv
ahb_to_axi_bridge.sv
axi_slave_model.sv
tb_ahb_to_axi.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ahb_to_axi -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" sim.log; then
  exit 1
fi

if ! grep -q "test passed" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi

exit 0
